// ==== sys_pkg.sv ====
`default_nettype none

package sys_pkg;

  // Bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  // Device indices on the decoder
  localparam int NR_DEVICES  = 3;
  localparam int DEV_RAM     = 0;
  localparam int DEV_SIMCTRL = 1;
  localparam int DEV_TIMER   = 2;

  // Device map, a device matches when (addr & MASK) == BASE
  localparam logic [ADDR_W-1:0] RAM_BASE     = 32'h0010_0000;
  localparam logic [ADDR_W-1:0] RAM_MASK     = ~32'h0000_0fff;
  localparam logic [ADDR_W-1:0] SIMCTRL_BASE = 32'h0002_0000;
  localparam logic [ADDR_W-1:0] SIMCTRL_MASK = ~32'h0000_03ff;
  localparam logic [ADDR_W-1:0] TIMER_BASE   = 32'h0003_0000;
  localparam logic [ADDR_W-1:0] TIMER_MASK   = ~32'h0000_03ff;

  // 4 KB of 32-bit words
  localparam int RAM_WORDS = 1024;

  // Timer register offsets
  localparam logic [ADDR_W-1:0] TIMER_MTIME_LO    = 32'h0;
  localparam logic [ADDR_W-1:0] TIMER_MTIME_HI    = 32'h4;
  localparam logic [ADDR_W-1:0] TIMER_MTIMECMP_LO = 32'h8;
  localparam logic [ADDR_W-1:0] TIMER_MTIMECMP_HI = 32'hc;

  // Simulation control register offsets
  localparam logic [ADDR_W-1:0] SIMCTRL_CHAR = 32'h0;
  localparam logic [ADDR_W-1:0] SIMCTRL_HALT = 32'h8;

endpackage

`default_nettype wire

// ==== dev_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dev_bus_if;

  // Request side, driven by the decoder
  logic                      req;
  logic                      we;
  logic [3:0]                be;
  logic [sys_pkg::ADDR_W-1:0] addr;
  logic [sys_pkg::DATA_W-1:0] wdata;

  // Response side, driven by the device one cycle after req
  logic                      rvalid;
  logic [sys_pkg::DATA_W-1:0] rdata;
  logic                      err;

  modport fabric (
    output req, we, be, addr, wdata,
    input  rvalid, rdata, err
  );

  modport device (
    input  req, we, be, addr, wdata,
    output rvalid, rdata, err
  );

endinterface

`default_nettype wire

// ==== bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       host_req_i,
  input  logic [sys_pkg::ADDR_W-1:0] host_addr_i,
  input  logic                       host_we_i,
  input  logic [3:0]                 host_be_i,
  input  logic [sys_pkg::DATA_W-1:0] host_wdata_i,
  output logic                       host_gnt_o,
  output logic                       host_rvalid_o,
  output logic [sys_pkg::DATA_W-1:0] host_rdata_o,
  output logic                       host_err_o,

  dev_bus_if.fabric                  dev_ram_o,
  dev_bus_if.fabric                  dev_simctrl_o,
  dev_bus_if.fabric                  dev_timer_o
);

  logic [sys_pkg::NR_DEVICES-1:0] hit;
  logic [sys_pkg::NR_DEVICES-1:0] hit_q;
  logic                           miss_q;

  // No arbitration, a single host is always granted
  assign host_gnt_o = host_req_i;

  // Base and mask match per device
  assign hit[sys_pkg::DEV_RAM] =
    (host_addr_i & sys_pkg::RAM_MASK) == sys_pkg::RAM_BASE;
  assign hit[sys_pkg::DEV_SIMCTRL] =
    (host_addr_i & sys_pkg::SIMCTRL_MASK) == sys_pkg::SIMCTRL_BASE;
  assign hit[sys_pkg::DEV_TIMER] =
    (host_addr_i & sys_pkg::TIMER_MASK) == sys_pkg::TIMER_BASE;

  // Request fan-out, only the matching port sees req
  assign dev_ram_o.req       = host_req_i & hit[sys_pkg::DEV_RAM];
  assign dev_ram_o.we        = host_we_i;
  assign dev_ram_o.be        = host_be_i;
  assign dev_ram_o.addr      = host_addr_i;
  assign dev_ram_o.wdata     = host_wdata_i;

  assign dev_simctrl_o.req   = host_req_i & hit[sys_pkg::DEV_SIMCTRL];
  assign dev_simctrl_o.we    = host_we_i;
  assign dev_simctrl_o.be    = host_be_i;
  assign dev_simctrl_o.addr  = host_addr_i;
  assign dev_simctrl_o.wdata = host_wdata_i;

  assign dev_timer_o.req     = host_req_i & hit[sys_pkg::DEV_TIMER];
  assign dev_timer_o.we      = host_we_i;
  assign dev_timer_o.be      = host_be_i;
  assign dev_timer_o.addr    = host_addr_i;
  assign dev_timer_o.wdata   = host_wdata_i;

  // Remember the target for the response cycle, one-hot or miss
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hit_q  <= '0;
      miss_q <= 1'b0;
    end else begin
      hit_q  <= host_req_i ? hit : '0;
      miss_q <= host_req_i & ~(|hit);
    end
  end

  // Response steering, an unmapped access answers by itself with err
  assign host_rvalid_o = miss_q
                       | (hit_q[sys_pkg::DEV_RAM]     & dev_ram_o.rvalid)
                       | (hit_q[sys_pkg::DEV_SIMCTRL] & dev_simctrl_o.rvalid)
                       | (hit_q[sys_pkg::DEV_TIMER]   & dev_timer_o.rvalid);

  assign host_rdata_o = ({sys_pkg::DATA_W{hit_q[sys_pkg::DEV_RAM]}}     & dev_ram_o.rdata)
                      | ({sys_pkg::DATA_W{hit_q[sys_pkg::DEV_SIMCTRL]}} & dev_simctrl_o.rdata)
                      | ({sys_pkg::DATA_W{hit_q[sys_pkg::DEV_TIMER]}}   & dev_timer_o.rdata);

  assign host_err_o = miss_q
                    | (hit_q[sys_pkg::DEV_RAM]     & dev_ram_o.err)
                    | (hit_q[sys_pkg::DEV_SIMCTRL] & dev_simctrl_o.err)
                    | (hit_q[sys_pkg::DEV_TIMER]   & dev_timer_o.err);

endmodule

`default_nettype wire

// ==== sram_dev.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_dev (
  input  logic       clk_i,
  dev_bus_if.device  bus_i
);

  logic [sys_pkg::DATA_W-1:0]              mem [sys_pkg::RAM_WORDS];
  logic [$clog2(sys_pkg::RAM_WORDS)-1:0]   word_idx;
  logic                                    rvalid_q;
  logic [sys_pkg::DATA_W-1:0]              rdata_q;

  // Word address within the 4 KB region
  assign word_idx = bus_i.addr[$clog2(sys_pkg::RAM_WORDS)+1:2];

  // Byte-enabled write port
  always_ff @(posedge clk_i) begin
    if (bus_i.req && bus_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (bus_i.be[b]) begin
          mem[word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Registered response, writes answer with zero data
  always_ff @(posedge clk_i) begin
    rvalid_q <= bus_i.req;
    if (bus_i.req) begin
      rdata_q <= bus_i.we ? '0 : mem[word_idx];
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  // RAM never faults
  assign bus_i.err    = 1'b0;

endmodule

`default_nettype wire

// ==== timer_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_regs (
  input  logic                       clk_i,
  input  logic                       reset_i,
  dev_bus_if.device                  bus_i,
  input  logic [63:0]                mtime_i,
  output logic                       load_lo_o,
  output logic                       load_hi_o,
  output logic [sys_pkg::DATA_W-1:0] load_data_o,
  output logic [63:0]                mtimecmp_o
);

  logic [sys_pkg::ADDR_W-1:0] offset;
  logic [sys_pkg::DATA_W-1:0] rd_data;
  logic                       offset_ok;
  logic                       wr;
  logic [63:0]                mtimecmp_q;
  logic                       rvalid_q;
  logic                       err_q;
  logic [sys_pkg::DATA_W-1:0] rdata_q;

  assign offset = bus_i.addr & ~sys_pkg::TIMER_MASK;
  assign wr     = bus_i.req & bus_i.we;

  // Register select and read mux
  always_comb begin
    offset_ok = 1'b1;
    case (offset)
      sys_pkg::TIMER_MTIME_LO:    rd_data = mtime_i[31:0];
      sys_pkg::TIMER_MTIME_HI:    rd_data = mtime_i[63:32];
      sys_pkg::TIMER_MTIMECMP_LO: rd_data = mtimecmp_q[31:0];
      sys_pkg::TIMER_MTIMECMP_HI: rd_data = mtimecmp_q[63:32];
      default: begin
        rd_data   = '0;
        offset_ok = 1'b0;
      end
    endcase
  end

  // Time writes go to the core as a load strobe in the request cycle
  assign load_lo_o   = wr & (offset == sys_pkg::TIMER_MTIME_LO);
  assign load_hi_o   = wr & (offset == sys_pkg::TIMER_MTIME_HI);
  assign load_data_o = bus_i.wdata;

  // Compare value, byte-enabled
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtimecmp_q <= '1;
    end else if (wr) begin
      for (int b = 0; b < 4; b++) begin
        if (bus_i.be[b] && offset == sys_pkg::TIMER_MTIMECMP_LO) begin
          mtimecmp_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
        if (bus_i.be[b] && offset == sys_pkg::TIMER_MTIMECMP_HI) begin
          mtimecmp_q[32+8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
      err_q    <= bus_i.req & ~offset_ok;
    end
  end

  // Read data payload
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      rdata_q <= bus_i.we ? '0 : rd_data;
    end
  end

  assign mtimecmp_o   = mtimecmp_q;
  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = err_q;

endmodule

`default_nettype wire

// ==== timer_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_core (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       load_lo_i,
  input  logic                       load_hi_i,
  input  logic [sys_pkg::DATA_W-1:0] load_data_i,
  input  logic [63:0]                mtimecmp_i,
  output logic [63:0]                mtime_o,
  output logic                       irq_o
);

  logic [63:0] mtime_q;
  logic        irq_q;

  // Free-running counter, a load replaces one half instead of counting
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_q <= '0;
    end else if (load_lo_i) begin
      mtime_q <= {mtime_q[63:32], load_data_i};
    end else if (load_hi_i) begin
      mtime_q <= {load_data_i, mtime_q[31:0]};
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // Unsigned compare, registered
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= (mtime_q >= mtimecmp_i);
    end
  end

  assign mtime_o = mtime_q;
  assign irq_o   = irq_q;

endmodule

`default_nettype wire

// ==== sim_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sim_ctrl (
  input  logic       clk_i,
  input  logic       reset_i,
  dev_bus_if.device  bus_i,
  output logic       char_valid_o,
  output logic [7:0] char_o,
  output logic       halt_o
);

  logic [sys_pkg::ADDR_W-1:0] offset;
  logic                       is_char;
  logic                       is_halt;
  logic                       char_valid_q;
  logic [7:0]                 char_q;
  logic                       halt_q;
  logic                       rvalid_q;
  logic                       err_q;

  assign offset  = bus_i.addr & ~sys_pkg::SIMCTRL_MASK;
  assign is_char = (offset == sys_pkg::SIMCTRL_CHAR);
  assign is_halt = (offset == sys_pkg::SIMCTRL_HALT);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      char_valid_q <= 1'b0;
      halt_q       <= 1'b0;
      rvalid_q     <= 1'b0;
      err_q        <= 1'b0;
    end else begin
      char_valid_q <= bus_i.req & bus_i.we & is_char;
      // Sticky until reset
      if (bus_i.req && bus_i.we && is_halt && bus_i.wdata[0]) begin
        halt_q <= 1'b1;
      end
      rvalid_q <= bus_i.req;
      err_q    <= bus_i.req & ~(is_char | is_halt);
    end
  end

  // Character byte, held between writes
  always_ff @(posedge clk_i) begin
    if (bus_i.req && bus_i.we && is_char) begin
      char_q <= bus_i.wdata[7:0];
    end
  end

  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;

  // Registers are write-only, reads see zero
  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = '0;
  assign bus_i.err    = err_q;

endmodule

`default_nettype wire

// ==== simple_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module simple_system (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       host_req_i,
  input  logic [sys_pkg::ADDR_W-1:0] host_addr_i,
  input  logic                       host_we_i,
  input  logic [3:0]                 host_be_i,
  input  logic [sys_pkg::DATA_W-1:0] host_wdata_i,
  output logic                       host_gnt_o,
  output logic                       host_rvalid_o,
  output logic [sys_pkg::DATA_W-1:0] host_rdata_o,
  output logic                       host_err_o,

  output logic                       timer_irq_o,
  output logic                       char_valid_o,
  output logic [7:0]                 char_o,
  output logic                       halt_o
);

  dev_bus_if ram_bus ();
  dev_bus_if simctrl_bus ();
  dev_bus_if timer_bus ();

  // Timer register block to counter
  logic [63:0]                mtime;
  logic [63:0]                mtimecmp;
  logic                       load_lo;
  logic                       load_hi;
  logic [sys_pkg::DATA_W-1:0] load_data;

  bus_decode u_bus_decode (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .dev_ram_o     (ram_bus.fabric),
    .dev_simctrl_o (simctrl_bus.fabric),
    .dev_timer_o   (timer_bus.fabric)
  );

  sram_dev u_sram (
    .clk_i (clk_i),
    .bus_i (ram_bus.device)
  );

  timer_regs u_timer_regs (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .bus_i       (timer_bus.device),
    .mtime_i     (mtime),
    .load_lo_o   (load_lo),
    .load_hi_o   (load_hi),
    .load_data_o (load_data),
    .mtimecmp_o  (mtimecmp)
  );

  timer_core u_timer_core (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_lo_i   (load_lo),
    .load_hi_i   (load_hi),
    .load_data_i (load_data),
    .mtimecmp_i  (mtimecmp),
    .mtime_o     (mtime),
    .irq_o       (timer_irq_o)
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .bus_i        (simctrl_bus.device),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

endmodule

`default_nettype wire

// ==== tb_simple_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_simple_system;

  localparam int RAM_OPS      = 200;
  localparam int UNMAPPED_OPS = 60;
  localparam int B2B_OPS      = 80;
  localparam int CHAR_OPS     = 16;
  // Well above the length of all tests together
  localparam int TIMEOUT_CYCLES = 4000;

  logic                       clk;
  logic                       reset;
  logic                       host_req;
  logic [sys_pkg::ADDR_W-1:0] host_addr;
  logic                       host_we;
  logic [3:0]                 host_be;
  logic [sys_pkg::DATA_W-1:0] host_wdata;
  logic                       host_gnt;
  logic                       host_rvalid;
  logic [sys_pkg::DATA_W-1:0] host_rdata;
  logic                       host_err;
  logic                       timer_irq;
  logic                       char_valid;
  logic [7:0]                 char_byte;
  logic                       halt;

  logic [31:0]                rng;
  int                         errors;
  int                         tests_passed;
  int                         tests_failed;
  int                         cycles;
  logic [sys_pkg::DATA_W-1:0] shadow [sys_pkg::RAM_WORDS];
  logic [3:0]                 known [sys_pkg::RAM_WORDS];
  logic [7:0]                 chars_seen [$];

  simple_system dut (
    .clk_i         (clk),
    .reset_i       (reset),
    .host_req_i    (host_req),
    .host_addr_i   (host_addr),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .host_err_o    (host_err),
    .timer_irq_o   (timer_irq),
    .char_valid_o  (char_valid),
    .char_o        (char_byte),
    .halt_o        (halt)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Character monitor
  always @(negedge clk) begin
    if (char_valid) begin
      chars_seen.push_back(char_byte);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] be_to_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  function automatic logic in_map(input logic [sys_pkg::ADDR_W-1:0] a);
    return ((a & sys_pkg::RAM_MASK) == sys_pkg::RAM_BASE) ||
           ((a & sys_pkg::SIMCTRL_MASK) == sys_pkg::SIMCTRL_BASE) ||
           ((a & sys_pkg::TIMER_MASK) == sys_pkg::TIMER_BASE);
  endfunction

  // Shadow RAM with a mask of the bytes written so far
  task ram_model_write(input logic [9:0] idx, input logic [3:0] be,
                       input logic [sys_pkg::DATA_W-1:0] wdata);
    logic [31:0] m;
    m = be_to_mask(be);
    shadow[idx] = (shadow[idx] & ~m) | (wdata & m);
    known[idx]  = known[idx] | be;
  endtask

  task check_data(input string name, input logic [sys_pkg::DATA_W-1:0] exp,
                  input logic [sys_pkg::DATA_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task check_char(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s with %0d errors", name, errors - errors_before);
    end
  endtask

  // One request from 1 ns after a rising edge to 1 ns after the edge that ends it
  task bus_access(input logic we, input logic [sys_pkg::ADDR_W-1:0] addr,
                  input logic [3:0] be, input logic [sys_pkg::DATA_W-1:0] wdata,
                  output logic [sys_pkg::DATA_W-1:0] rdata, output logic err);
    int waited;
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_be    = be;
    host_wdata = wdata;
    @(posedge clk);
    #1;
    host_req = 1'b0;
    host_we  = 1'b0;
    waited   = 0;
    @(negedge clk);
    while (!host_rvalid && waited < 8) begin
      waited++;
      @(negedge clk);
    end
    rdata = host_rdata;
    err   = host_err;
    if (!host_rvalid) begin
      $display("No response within 8 cycles of a request to address %h", addr);
      errors++;
    end else if (waited != 0) begin
      $display("Response to address %h came %0d cycles late", addr, waited);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    logic [sys_pkg::DATA_W-1:0] rdata;
    logic                       err;
    logic                       we;
    logic [3:0]                 be;
    logic [9:0]                 idx;
    logic [31:0]                wdata;
    logic [31:0]                addr;
    logic [31:0]                m;
    logic [31:0]                t_lo;
    logic [31:0]                t_hi;
    logic [31:0]                rd_lo;
    logic [31:0]                rd_hi;
    logic [63:0]                cmp;
    logic [31:0]                cur_exp;
    logic [31:0]                cur_mask;
    logic [31:0]                prev_exp;
    logic [31:0]                prev_mask;
    logic [7:0]                 ch;
    int                         start;

    rng          = 32'hca23_9289;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles       = 0;
    reset        = 1'b1;
    host_req     = 1'b0;
    host_addr    = '0;
    host_we      = 1'b0;
    host_be      = 4'h0;
    host_wdata   = '0;
    for (int i = 0; i < sys_pkg::RAM_WORDS; i++) begin
      known[i]  = 4'h0;
      shadow[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // 32 words spread over the whole region
    start = errors;
    for (int n = 0; n < RAM_OPS; n++) begin
      rng   = xorshift32(rng);
      idx   = {rng[9:8], 5'd0, rng[2:0]};
      we    = rng[16];
      be    = rng[23:20];
      rng   = xorshift32(rng);
      wdata = rng;
      addr  = sys_pkg::RAM_BASE | {20'd0, idx, 2'b00};
      if (!we) begin
        m = be_to_mask(known[idx]);
      end
      bus_access(we, addr, be, wdata, rdata, err);
      check_bit("ram err", 1'b0, err);
      if (we) begin
        ram_model_write(idx, be, wdata);
        check_data("ram write response", '0, rdata);
      end else begin
        check_data("ram read", shadow[idx] & m, rdata & m);
      end
    end
    report_test("ram_random", start);

    start = errors;
    for (int n = 0; n < UNMAPPED_OPS; n++) begin
      // Word bits aim at the tracked RAM words so a stray write would show
      rng  = xorshift32(rng);
      addr = {rng[31:12], rng[11:10], 5'd0, rng[2:0], 2'b00};
      while (in_map(addr)) begin
        rng  = xorshift32(rng);
        addr = {rng[31:12], rng[11:10], 5'd0, rng[2:0], 2'b00};
      end
      rng = xorshift32(rng);
      bus_access(rng[0], addr, rng[7:4], rng, rdata, err);
      check_bit("unmapped err", 1'b1, err);
    end
    // RAM contents must be untouched
    for (int i = 0; i < 32; i++) begin
      idx = {i[4:3], 5'd0, i[2:0]};
      m   = be_to_mask(known[idx]);
      bus_access(1'b0, sys_pkg::RAM_BASE | {20'd0, idx, 2'b00}, 4'hf, '0, rdata, err);
      check_data("ram after unmapped", shadow[idx] & m, rdata & m);
    end
    report_test("unmapped", start);

    start     = errors;
    prev_exp  = '0;
    prev_mask = '0;
    for (int n = 0; n <= B2B_OPS; n++) begin
      cur_exp  = '0;
      cur_mask = '1;
      if (n < B2B_OPS) begin
        rng   = xorshift32(rng);
        idx   = {rng[9:8], 5'd0, rng[2:0]};
        we    = rng[16];
        be    = rng[23:20];
        rng   = xorshift32(rng);
        wdata = rng;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = sys_pkg::RAM_BASE | {20'd0, idx, 2'b00};
        host_be    = be;
        host_wdata = wdata;
        if (we) begin
          ram_model_write(idx, be, wdata);
        end else begin
          cur_mask = be_to_mask(known[idx]);
          cur_exp  = shadow[idx] & cur_mask;
        end
      end else begin
        host_req = 1'b0;
        host_we  = 1'b0;
      end
      @(negedge clk);
      if (n < B2B_OPS) begin
        check_bit("b2b gnt", 1'b1, host_gnt);
      end
      if (n > 0) begin
        if (!host_rvalid) begin
          $display("Back-to-back request %0d got no response in the next cycle", n - 1);
          errors++;
        end else begin
          check_bit("b2b err", 1'b0, host_err);
          check_data("b2b data", prev_exp, host_rdata & prev_mask);
        end
      end
      prev_exp  = cur_exp;
      prev_mask = cur_mask;
      @(posedge clk);
      #1;
    end
    @(negedge clk);
    check_bit("b2b idle rvalid", 1'b0, host_rvalid);
    @(posedge clk);
    #1;
    report_test("back_to_back", start);

    start = errors;
    check_bit("irq after reset", 1'b0, timer_irq);
    rng  = xorshift32(rng);
    t_lo = {1'b0, rng[30:0]};
    rng  = xorshift32(rng);
    t_hi = rng;
    bus_access(1'b1, sys_pkg::TIMER_BASE | sys_pkg::TIMER_MTIME_LO, 4'hf, t_lo, rdata, err);
    check_bit("mtime lo write err", 1'b0, err);
    bus_access(1'b1, sys_pkg::TIMER_BASE | sys_pkg::TIMER_MTIME_HI, 4'hf, t_hi, rdata, err);
    bus_access(1'b0, sys_pkg::TIMER_BASE | sys_pkg::TIMER_MTIME_LO, 4'hf, '0, rd_lo, err);
    bus_access(1'b0, sys_pkg::TIMER_BASE | sys_pkg::TIMER_MTIME_HI, 4'hf, '0, rd_hi, err);
    if (rd_lo < t_lo || rd_lo > t_lo + 32'd10) begin
      $display("[ERROR] mtime lo expected %h to %h actual %h", t_lo, t_lo + 32'd10, rd_lo);
      errors++;
    end
    check_data("mtime hi", t_hi, rd_hi);
    cmp = {rd_hi, rd_lo} + 64'd30;
    bus_access(1'b1, sys_pkg::TIMER_BASE | sys_pkg::TIMER_MTIMECMP_HI, 4'hf, cmp[63:32],
               rdata, err);
    bus_access(1'b1, sys_pkg::TIMER_BASE | sys_pkg::TIMER_MTIMECMP_LO, 4'hf, cmp[31:0],
               rdata, err);
    check_bit("irq before compare", 1'b0, timer_irq);
    bus_access(1'b0, sys_pkg::TIMER_BASE | sys_pkg::TIMER_MTIMECMP_LO, 4'hf, '0, rdata, err);
    check_data("mtimecmp lo", cmp[31:0], rdata);
    repeat (60) @(posedge clk);
    #1;
    check_bit("irq after compare", 1'b1, timer_irq);
    bus_access(1'b1, sys_pkg::TIMER_BASE | sys_pkg::TIMER_MTIMECMP_HI, 4'hf, '1, rdata, err);
    bus_access(1'b1, sys_pkg::TIMER_BASE | sys_pkg::TIMER_MTIMECMP_LO, 4'hf, '1, rdata, err);
    check_bit("irq cleared", 1'b0, timer_irq);
    bus_access(1'b0, sys_pkg::TIMER_BASE | 32'h10, 4'hf, '0, rdata, err);
    check_bit("timer bad offset err", 1'b1, err);
    report_test("timer", start);

    start = errors;
    check_bit("halt after reset", 1'b0, halt);
    for (int n = 0; n < CHAR_OPS; n++) begin
      rng = xorshift32(rng);
      ch  = rng[7:0];
      bus_access(1'b1, sys_pkg::SIMCTRL_BASE | sys_pkg::SIMCTRL_CHAR, 4'h1, rng, rdata, err);
      check_bit("char write err", 1'b0, err);
      if (chars_seen.size() != 1) begin
        $display("Character write %0d gave %0d pulses instead of one", n, chars_seen.size());
        errors++;
      end
      if (chars_seen.size() > 0) begin
        check_char("char byte", ch, chars_seen[0]);
      end
      chars_seen.delete();
    end
    bus_access(1'b0, sys_pkg::SIMCTRL_BASE | sys_pkg::SIMCTRL_CHAR, 4'hf, '0, rdata, err);
    check_data("simctrl read data", '0, rdata);
    check_bit("simctrl read err", 1'b0, err);
    bus_access(1'b1, sys_pkg::SIMCTRL_BASE | sys_pkg::SIMCTRL_HALT, 4'hf, 32'h2, rdata, err);
    check_bit("halt with bit 0 clear", 1'b0, halt);
    bus_access(1'b1, sys_pkg::SIMCTRL_BASE | sys_pkg::SIMCTRL_HALT, 4'hf, 32'h1, rdata, err);
    check_bit("halt set", 1'b1, halt);
    bus_access(1'b1, sys_pkg::SIMCTRL_BASE | sys_pkg::SIMCTRL_HALT, 4'hf, 32'h0, rdata, err);
    check_bit("halt sticky", 1'b1, halt);
    bus_access(1'b0, sys_pkg::SIMCTRL_BASE | 32'h4, 4'hf, '0, rdata, err);
    check_bit("simctrl bad offset err", 1'b1, err);
    repeat (4) @(posedge clk);
    #1;
    if (chars_seen.size() != 0) begin
      $display("Saw %0d character pulses without a character write", chars_seen.size());
      errors++;
    end
    report_test("sim_ctrl", start);

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
sys_pkg.sv
dev_bus_if.sv
bus_decode.sv
sram_dev.sv
timer_regs.sv
timer_core.sv
sim_ctrl.sv
simple_system.sv
tb_simple_system.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timescale 1ns/1ps --top-module tb_simple_system -f flist.f \
  -o sim_tb && ./obj_dir/sim_tb | grep "TEST PASS" || exit 1
